// File: alice_cascade_top.sv
//########################################
// alice cascade engine, ram and fifo ports
//########################################
`timescale 1ns/1ps

module alice_cascade_top
    import cascade_pkg::*;
#(
    parameter int KEY_LEN = 1024,
    parameter int ROUND_W = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_i,
    input  logic                                    key_bank_i,
    input  logic [ROUND_W-1:0]                      frame_round_i,
    output logic [ram_addr_w(KEY_LEN, ROUND_W)-1:0] bram_addr_o,
    input  logic [RAM_W-1:0]                        bram_dout_i,
    input  logic [WORD_W-1:0]                       b2a_dout_i,
    input  logic                                    b2a_empty_i,
    output logic                                    b2a_rd_en_o,
    output logic                                    a2b_wr_en_o,
    output logic [WORD_W-1:0]                       a2b_din_o,
    output logic [ERR_CNT_W-1:0]                    frame_error_count_o,
    output logic [LEAK_W-1:0]                       frame_leaked_info_o,
    output logic                                    frame_param_valid_o,
    output logic                                    cascade_finish_o,
    output logic [KEY_LEN-1:0]                      corrected_key_o
);

    logic load_en;
    logic load_done;
    logic hdr_rd;
    logic reply_en;
    logic reply_done;
    logic frame_settle;
    logic settled_ok;

    key_if #(.KEY_LEN(KEY_LEN)) i_key_if ();

    cascade_sequencer i_cascade_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .b2a_empty_i    (b2a_empty_i),
        .load_done_i    (load_done),
        .reply_done_i   (reply_done),
        .settled_ok_i   (settled_ok),
        .load_en_o      (load_en),
        .hdr_rd_o       (hdr_rd),
        .reply_en_o     (reply_en),
        .frame_settle_o (frame_settle),
        .param_valid_o  (frame_param_valid_o),
        .finish_o       (cascade_finish_o)
    );

    sifted_key_loader #(.KEY_LEN(KEY_LEN), .ROUND_W(ROUND_W)) i_sifted_key_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_en_i     (load_en),
        .key_bank_i    (key_bank_i),
        .frame_round_i (frame_round_i),
        .bram_addr_o   (bram_addr_o),
        .bram_dout_i   (bram_dout_i),
        .load_done_o   (load_done),
        .kif           (i_key_if.writer)
    );

    key_parity_store #(.KEY_LEN(KEY_LEN)) i_key_parity_store (
        .clk             (clk),
        .rst_n           (rst_n),
        .kif             (i_key_if.store),
        .corrected_key_o (corrected_key_o)
    );

    parity_responder #(.KEY_LEN(KEY_LEN)) i_parity_responder (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hdr_rd_i            (hdr_rd),
        .reply_en_i          (reply_en),
        .frame_settle_i      (frame_settle),
        .finish_i            (cascade_finish_o),
        .b2a_dout_i          (b2a_dout_i),
        .b2a_rd_en_o         (b2a_rd_en_o),
        .a2b_wr_en_o         (a2b_wr_en_o),
        .a2b_din_o           (a2b_din_o),
        .reply_done_o        (reply_done),
        .settled_ok_o        (settled_ok),
        .frame_error_count_o (frame_error_count_o),
        .frame_leaked_info_o (frame_leaked_info_o),
        .kif                 (i_key_if.reader)
    );

endmodule

// File: cascade_pkg.sv
//########################################
// shared header layout, codes and key-size helpers for the cascade engine
// imported by wildcard in every design module that needs them
//########################################
package cascade_pkg;

    // fifo and key word width
    localparam int WORD_W = 32;
    // sifted-key ram word width
    localparam int RAM_W = 64;

    localparam int ERR_CNT_W = 15;
    localparam int LEAK_W = 16;
    localparam int ROW_W = 4;

    // message type of every header alice writes
    localparam logic [3:0] MSG_A2B_CORRECT_PARITY = 4'd3;
    // length code of a closing header after a clean comparison
    localparam logic [3:0] LEN_CODE_257 = 4'd1;

    // parity types, bit 2 marks top level
    localparam logic [2:0] PT_NORMAL = 3'b000;
    localparam logic [2:0] PT_TOP_MESSAGE = 3'b100;
    localparam logic [2:0] PT_FIRST_TOP_MESSAGE = 3'b101;
    localparam logic [2:0] PT_TOP_COMPARE = 3'b110;
    localparam logic [2:0] PT_TOP_CORRECT = 3'b111;

    typedef struct packed {
        logic [3:0] msg_type;
        logic [3:0] len_code;
        logic [8:0] depth;
        logic [2:0] ptype;
        logic [2:0] shuffle_set;
        logic [3:0] row;
        logic [4:0] tag;
    } hdr_t;

    // index width, never below one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // 32-bit words in the key
    function automatic int word_cnt(input int key_len);
        return key_len / WORD_W;
    endfunction

    // 64-bit ram entries per frame
    function automatic int ram_depth(input int key_len);
        return key_len / RAM_W;
    endfunction

    // rows whose vector still holds at least one word
    function automatic int row_cnt(input int key_len);
        return $clog2(key_len / WORD_W) + 1;
    endfunction

    // bank bit, frame round, entry number
    function automatic int ram_addr_w(input int key_len, input int round_w);
        return 1 + round_w + idx_w(ram_depth(key_len));
    endfunction

endpackage

// File: cascade_sequencer.sv
//########################################
// control FSM: load, serve requests, close the frame
//########################################
`timescale 1ns/1ps

module cascade_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic b2a_empty_i,
    input  logic load_done_i,
    input  logic reply_done_i,
    input  logic settled_ok_i,
    output logic load_en_o,
    output logic hdr_rd_o,
    output logic reply_en_o,
    output logic frame_settle_o,
    output logic param_valid_o,
    output logic finish_o
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT_HDR,
        S_READ_HDR,
        S_SETUP,
        S_REPLY,
        S_SETTLE,
        S_PARAM_OUT,
        S_END
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (start_i) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD: begin
                if (load_done_i) begin
                    state_nxt = S_WAIT_HDR;
                end
            end
            // empty flag stands in for read-valid
            S_WAIT_HDR: begin
                if (!b2a_empty_i) begin
                    state_nxt = S_READ_HDR;
                end
            end
            S_READ_HDR: state_nxt = S_SETUP;
            S_SETUP:    state_nxt = S_REPLY;
            S_REPLY: begin
                if (reply_done_i) begin
                    state_nxt = S_SETTLE;
                end
            end
            S_SETTLE:    state_nxt = settled_ok_i ? S_PARAM_OUT : S_WAIT_HDR;
            S_PARAM_OUT: state_nxt = S_END;
            S_END:       state_nxt = S_IDLE;
            default:     state_nxt = S_IDLE;
        endcase
    end

    assign load_en_o = (state == S_LOAD);
    assign hdr_rd_o = (state == S_READ_HDR);
    assign reply_en_o = (state == S_REPLY);
    assign frame_settle_o = (state == S_SETTLE);
    assign param_valid_o = (state == S_PARAM_OUT);
    assign finish_o = (state == S_END);

endmodule

// File: key_if.sv
//########################################
// key write and parity-word read path
// loader writes, responder reads, store serves both
//########################################
`timescale 1ns/1ps

interface key_if
    import cascade_pkg::*;
#(
    parameter int KEY_LEN = 1024
);

    localparam int WIDX_W = idx_w(word_cnt(KEY_LEN));

    // write side, one word per strobe
    logic              wr_en;
    logic [WIDX_W-1:0] wr_idx;
    logic [WORD_W-1:0] wr_word;

    // read side, rd_word is combinational
    logic [ROW_W-1:0]  rd_row;
    logic [WIDX_W-1:0] rd_idx;
    logic [WORD_W-1:0] rd_word;

    modport writer (output wr_en, wr_idx, wr_word);
    modport reader (output rd_row, rd_idx, input rd_word);
    modport store (input wr_en, wr_idx, wr_word, rd_row, rd_idx, output rd_word);

endinterface

// File: key_parity_store.sv
//########################################
// key register and its parity tree
// serves one left-aligned parity word per row and word index
//########################################
`timescale 1ns/1ps

module key_parity_store
    import cascade_pkg::*;
#(
    parameter int KEY_LEN = 1024
) (
    input  logic               clk,
    input  logic               rst_n,
    key_if.store               kif,
    output logic [KEY_LEN-1:0] corrected_key_o
);

    localparam int N_ROWS = row_cnt(KEY_LEN);

    logic [KEY_LEN-1:0] key_q;
    logic [KEY_LEN-1:0] aligned [1:N_ROWS];

    // word 0 is the most significant word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_q <= '0;
        end else if (kif.wr_en) begin
            key_q[KEY_LEN-1-WORD_W*int'(kif.wr_idx) -: WORD_W] <= kif.wr_word;
        end
    end

    assign corrected_key_o = key_q;

    // row r bit j covers key bits j*2^(r-1) upward over 2^(r-1) bits
    for (genvar r = 1; r <= N_ROWS; r++) begin : g_row
        localparam int SPAN = 1 << (r - 1);
        localparam int W = KEY_LEN >> (r - 1);

        logic [W-1:0] vec;

        for (genvar j = 0; j < W; j++) begin : g_bit
            assign vec[j] = ^key_q[j*SPAN +: SPAN];
        end

        // left-aligned, zeros below
        assign aligned[r] = KEY_LEN'(vec) << (KEY_LEN - W);
    end

    always_comb begin
        logic [KEY_LEN-1:0] row_sel;

        row_sel = '0;
        for (int r = 1; r <= N_ROWS; r++) begin
            if (int'(kif.rd_row) == r) begin
                row_sel = aligned[r];
            end
        end
        // unused rows read as zero
        kif.rd_word = row_sel[KEY_LEN-1-WORD_W*int'(kif.rd_idx) -: WORD_W];
    end

endmodule

// File: parity_responder.sv
//########################################
// answers one parity request from bob and keeps the frame totals
// driven by the sequencer's header, reply, settle and finish controls
//########################################
`timescale 1ns/1ps

module parity_responder
    import cascade_pkg::*;
#(
    parameter int KEY_LEN = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hdr_rd_i,
    input  logic                 reply_en_i,
    input  logic                 frame_settle_i,
    input  logic                 finish_i,
    input  logic [WORD_W-1:0]    b2a_dout_i,
    output logic                 b2a_rd_en_o,
    output logic                 a2b_wr_en_o,
    output logic [WORD_W-1:0]    a2b_din_o,
    output logic                 reply_done_o,
    output logic                 settled_ok_o,
    output logic [ERR_CNT_W-1:0] frame_error_count_o,
    output logic [LEAK_W-1:0]    frame_leaked_info_o,
    key_if.reader                kif
);

    localparam int WORD_CNT = word_cnt(KEY_LEN);
    localparam int WIDX_W = idx_w(WORD_CNT);
    localparam int CNT_W = WIDX_W + 2;

    hdr_t                 hdr_q;
    logic [CNT_W-1:0]     cnt;
    logic [CNT_W-1:0]     depth_eff;
    logic [ERR_CNT_W-1:0] pkt_err;
    logic                 top;
    logic                 open_phase;
    logic                 word_phase;
    logic                 close_phase;
    logic [WORD_W-1:0]    reply_word;
    hdr_t                 open_hdr;
    hdr_t                 close_hdr;
    logic [LEAK_W-1:0]    leak_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_q <= '0;
        end else if (hdr_rd_i) begin
            hdr_q <= hdr_t'(b2a_dout_i);
        end
    end

    assign top = hdr_q.ptype[2];
    // depth used directly, capped at the key's word count
    assign depth_eff = (int'(hdr_q.depth) > WORD_CNT) ? CNT_W'(WORD_CNT) : CNT_W'(hdr_q.depth);

    // 0 opening header, 1..depth words, depth+1 closing header
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (reply_en_i) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    assign open_phase = reply_en_i && (cnt == '0);
    assign word_phase = reply_en_i && (cnt != '0) && (cnt <= depth_eff);
    assign close_phase = reply_en_i && (cnt == depth_eff + 1'b1);
    assign reply_done_o = close_phase;

    assign kif.rd_row = hdr_q.row;
    assign kif.rd_idx = WIDX_W'(cnt - 1'b1);

    // top level sends alice's parity, normal masks it with bob's word
    assign reply_word = top ? kif.rd_word : (kif.rd_word & b2a_dout_i);

    always_comb begin
        open_hdr = hdr_q;
        open_hdr.msg_type = MSG_A2B_CORRECT_PARITY;
        if (top) begin
            open_hdr.ptype = PT_TOP_COMPARE;
            open_hdr.depth = hdr_q.depth + 1'b1;
        end else begin
            open_hdr.ptype = PT_NORMAL;
        end

        close_hdr = hdr_q;
        close_hdr.msg_type = MSG_A2B_CORRECT_PARITY;
        if (pkt_err == '0) begin
            close_hdr.len_code = LEN_CODE_257;
            close_hdr.depth = '0;
            close_hdr.ptype = PT_TOP_CORRECT;
        end else begin
            close_hdr.ptype = PT_TOP_MESSAGE;
        end
    end

    assign b2a_rd_en_o = hdr_rd_i || word_phase;
    assign a2b_wr_en_o = open_phase || word_phase || (close_phase && top);
    assign a2b_din_o = open_phase  ? WORD_W'(open_hdr)  :
                       close_phase ? WORD_W'(close_hdr) : reply_word;

    // mismatched parity bits of this packet
    always_ff @(posedge clk) begin
        if (!rst_n || hdr_rd_i) begin
            pkt_err <= '0;
        end else if (word_phase && top) begin
            pkt_err <= pkt_err + ERR_CNT_W'($countones(kif.rd_word ^ b2a_dout_i));
        end
    end

    assign settled_ok_o = (pkt_err == '0) && (hdr_q.ptype == PT_FIRST_TOP_MESSAGE);

    // bits revealed by the shuffle sets below this row
    always_comb begin
        leak_sum = '0;
        for (int s = 1; s <= 4; s++) begin
            if ((hdr_q.shuffle_set <= 3'd4) && (s <= int'(hdr_q.shuffle_set))
                    && (s <= int'(hdr_q.row))) begin
                leak_sum = leak_sum + LEAK_W'(KEY_LEN >> (int'(hdr_q.row) - s));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || finish_i) begin
            frame_error_count_o <= '0;
            frame_leaked_info_o <= '0;
        end else if (frame_settle_i && top) begin
            frame_error_count_o <= frame_error_count_o + pkt_err;
            if (settled_ok_o) begin
                frame_leaked_info_o <= frame_leaked_info_o + leak_sum;
            end else begin
                frame_leaked_info_o <= frame_leaked_info_o
                                       + LEAK_W'(pkt_err) * LEAK_W'(hdr_q.row - 1'b1);
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message shows up
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal -f vlog.f --top-module tb_alice_cascade -o tb_alice_cascade
out=$(./obj_dir/tb_alice_cascade)
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// File: sifted_key_loader.sv
//########################################
// copies one frame of sifted key from ram into the key store
// runs while load_en_i is high, flags load_done_o at the end
//########################################
`timescale 1ns/1ps

module sifted_key_loader
    import cascade_pkg::*;
#(
    parameter int KEY_LEN = 1024,
    parameter int ROUND_W = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      load_en_i,
    input  logic                                      key_bank_i,
    input  logic [ROUND_W-1:0]                        frame_round_i,
    output logic [ram_addr_w(KEY_LEN, ROUND_W)-1:0]   bram_addr_o,
    input  logic [RAM_W-1:0]                          bram_dout_i,
    output logic                                      load_done_o,
    key_if.writer                                     kif
);

    localparam int RAM_DEPTH = ram_depth(KEY_LEN);
    localparam int ENTRY_W = idx_w(RAM_DEPTH);
    localparam int WIDX_W = idx_w(word_cnt(KEY_LEN));
    localparam int CNT_W = ENTRY_W + 2;
    // one ram cycle plus the output register before the first word
    localparam int FIRST_WR = 2;
    localparam int LAST_WR = 2 * RAM_DEPTH + 1;
    localparam int DONE_CNT = LAST_WR + 2;

    logic [CNT_W-1:0] cnt;
    logic [RAM_W-1:0] dout_q;

    // two cycles per entry, one per half
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load_en_i) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        dout_q <= bram_dout_i;
    end

    assign bram_addr_o = {key_bank_i, frame_round_i, cnt[ENTRY_W:1]};

    // even count takes the upper half, odd the lower
    assign kif.wr_en = load_en_i && (int'(cnt) >= FIRST_WR) && (int'(cnt) <= LAST_WR);
    assign kif.wr_idx = WIDX_W'(cnt - CNT_W'(FIRST_WR));
    assign kif.wr_word = cnt[0] ? dout_q[WORD_W-1:0] : dout_q[RAM_W-1:WORD_W];

    assign load_done_o = load_en_i && (int'(cnt) == DONE_CNT);

endmodule

// File: tb_alice_cascade.sv
//########################################
// directed testbench for the alice cascade engine
// models the key ram and both fifos, checks replies against a parity model
//########################################
`timescale 1ns/1ps

module tb_alice_cascade
    import cascade_pkg::*;
();

    localparam int KEY_LEN = 1024;
    localparam int ROUND_W = 2;
    localparam int WORDS = word_cnt(KEY_LEN);
    localparam int ENTRIES = ram_depth(KEY_LEN);
    localparam int ENTRY_W = idx_w(ENTRIES);
    localparam int ADDR_W = ram_addr_w(KEY_LEN, ROUND_W);
    localparam int CLK_PERIOD = 40;
    localparam int LOAD_CYCLES = 2 * ENTRIES + 6;
    localparam int REQ_CYCLES = WORDS + 12;
    // reset, two loads, four requests, frame end and slack
    localparam int RUN_CYCLES = 4 + 2 * (LOAD_CYCLES + 2) + 4 * (REQ_CYCLES + 4) + 100;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   start_i = 1'b0;
    logic                   key_bank_i = 1'b0;
    logic [ROUND_W-1:0]     frame_round_i = '0;
    logic [ADDR_W-1:0]      bram_addr_o;
    logic [RAM_W-1:0]       bram_dout_i = '0;
    logic [WORD_W-1:0]      b2a_dout_i = '0;
    logic                   b2a_empty_i = 1'b1;
    logic                   b2a_rd_en_o;
    logic                   a2b_wr_en_o;
    logic [WORD_W-1:0]      a2b_din_o;
    logic [ERR_CNT_W-1:0]   frame_error_count_o;
    logic [LEAK_W-1:0]      frame_leaked_info_o;
    logic                   frame_param_valid_o;
    logic                   cascade_finish_o;
    logic [KEY_LEN-1:0]     corrected_key_o;

    logic [RAM_W-1:0]       ram [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0]      ram_addr_q = '0;
    logic                   pop_q = 1'b0;
    logic [WORD_W-1:0]      b2a_q [$];
    logic [WORD_W-1:0]      a2b_q [$];
    logic [WORD_W-1:0]      bob_q [$];
    logic [WORD_W-1:0]      expect_q [$];
    logic [KEY_LEN-1:0]     exp_key = '0;
    logic [ERR_CNT_W-1:0]   param_err = '0;
    logic [LEAK_W-1:0]      param_leak = '0;
    int                     exp_err = 0;
    int                     exp_leak = 0;
    int                     val_errs = 0;
    int                     other_errs = 0;
    int                     cycle_cnt = 0;
    int                     param_cnt = 0;
    int                     finish_cnt = 0;
    int                     param_cycle = 0;
    int                     finish_cycle = 0;

    alice_cascade_top i_alice_cascade_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start_i             (start_i),
        .key_bank_i          (key_bank_i),
        .frame_round_i       (frame_round_i),
        .bram_addr_o         (bram_addr_o),
        .bram_dout_i         (bram_dout_i),
        .b2a_dout_i          (b2a_dout_i),
        .b2a_empty_i         (b2a_empty_i),
        .b2a_rd_en_o         (b2a_rd_en_o),
        .a2b_wr_en_o         (a2b_wr_en_o),
        .a2b_din_o           (a2b_din_o),
        .frame_error_count_o (frame_error_count_o),
        .frame_leaked_info_o (frame_leaked_info_o),
        .frame_param_valid_o (frame_param_valid_o),
        .cascade_finish_o    (cascade_finish_o),
        .corrected_key_o     (corrected_key_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // sample design outputs where the design samples its inputs
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        ram_addr_q <= bram_addr_o;
        pop_q <= b2a_rd_en_o && rst_n;
        if (rst_n && a2b_wr_en_o) begin
            a2b_q.push_back(a2b_din_o);
        end
        if (rst_n && frame_param_valid_o) begin
            param_cnt = param_cnt + 1;
            param_cycle = cycle_cnt;
            param_err = frame_error_count_o;
            param_leak = frame_leaked_info_o;
        end
        if (rst_n && cascade_finish_o) begin
            finish_cnt = finish_cnt + 1;
            finish_cycle = cycle_cnt;
        end
    end

    // ram data one cycle after the address, fwft fifo head and pops
    always @(negedge clk) begin
        bram_dout_i <= ram[ram_addr_q];
        if (pop_q) begin
            if (b2a_q.size() == 0) begin
                other_errs++;
                $display("%0t: design popped the B2A FIFO while it was empty", $time);
            end else begin
                void'(b2a_q.pop_front());
            end
        end
        b2a_empty_i <= (b2a_q.size() == 0);
        b2a_dout_i <= (b2a_q.size() == 0) ? '0 : b2a_q[0];
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        val_errs++;
        $display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
    endtask

    // entry 0 of the frame lands in the key's top bits
    function automatic logic [KEY_LEN-1:0] frame_key(input logic bank, input int round);
        logic [KEY_LEN-1:0] k;
        int addr;
        k = '0;
        for (int e = 0; e < ENTRIES; e++) begin
            addr = (int'(bank) << (ROUND_W + ENTRY_W)) | (round << ENTRY_W) | e;
            k[KEY_LEN-1-RAM_W*e -: RAM_W] = ram[addr];
        end
        return k;
    endfunction

    // each row pairs neighbour bits of the row below and is left-aligned
    function automatic logic [KEY_LEN-1:0] parity_row(input logic [KEY_LEN-1:0] key,
                                                      input int row);
        logic [KEY_LEN-1:0] v;
        int w;
        v = key;
        w = KEY_LEN;
        for (int r = 2; r <= row; r++) begin
            w = w / 2;
            for (int j = 0; j < w; j++) begin
                v[j] = v[2*j] ^ v[2*j+1];
            end
            v = v & ((KEY_LEN'(1) << w) - KEY_LEN'(1));
        end
        return v << (KEY_LEN - w);
    endfunction

    task automatic check_totals();
        if (frame_error_count_o !== ERR_CNT_W'(exp_err)) begin
            report_mismatch("frame_error_count_o", frame_error_count_o, exp_err);
        end
        if (frame_leaked_info_o !== LEAK_W'(exp_leak)) begin
            report_mismatch("frame_leaked_info_o", frame_leaked_info_o, exp_leak);
        end
    endtask

    task automatic check_reset_state();
        if (bram_addr_o !== '0) report_mismatch("bram_addr_o", bram_addr_o, 0);
        if (b2a_rd_en_o !== 1'b0) report_mismatch("b2a_rd_en_o", b2a_rd_en_o, 0);
        if (a2b_wr_en_o !== 1'b0) report_mismatch("a2b_wr_en_o", a2b_wr_en_o, 0);
        if (frame_param_valid_o !== 1'b0) begin
            report_mismatch("frame_param_valid_o", frame_param_valid_o, 0);
        end
        if (cascade_finish_o !== 1'b0) report_mismatch("cascade_finish_o", cascade_finish_o, 0);
        if (corrected_key_o !== '0) begin
            other_errs++;
            $display("%0t: corrected_key_o is not zero after reset", $time);
        end
        check_totals();
    endtask

    task automatic load_frame(input logic bank, input logic [ROUND_W-1:0] round);
        key_bank_i = bank;
        frame_round_i = round;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        repeat (LOAD_CYCLES) @(negedge clk);
        exp_key = frame_key(bank, int'(round));
        for (int w = 0; w < WORDS; w++) begin
            if (corrected_key_o[KEY_LEN-1-WORD_W*w -: WORD_W]
                    !== exp_key[KEY_LEN-1-WORD_W*w -: WORD_W]) begin
                report_mismatch($sformatf("corrected_key_o word %0d", w),
                                corrected_key_o[KEY_LEN-1-WORD_W*w -: WORD_W],
                                exp_key[KEY_LEN-1-WORD_W*w -: WORD_W]);
            end
        end
    endtask

    // header and words go in together and show from the next falling edge
    task automatic send_request(input hdr_t hdr);
        a2b_q.delete();
        @(posedge clk);
        b2a_q.push_back(WORD_W'(hdr));
        foreach (bob_q[i]) begin
            b2a_q.push_back(bob_q[i]);
        end
        @(negedge clk);
    endtask

    task automatic check_replies(input string what);
        int waited;
        waited = 0;
        while ((a2b_q.size() < expect_q.size()) && (waited < REQ_CYCLES)) begin
            @(negedge clk);
            waited++;
        end
        // close and settle cycles
        repeat (3) @(negedge clk);
        if (b2a_q.size() != 0) begin
            other_errs++;
            $display("%0t: %s request left %0d words unread in the B2A FIFO", $time, what,
                     b2a_q.size());
        end
        if (a2b_q.size() != expect_q.size()) begin
            other_errs++;
            $display("%0t: %s request gave %0d A2B words instead of %0d", $time, what,
                     a2b_q.size(), expect_q.size());
        end else begin
            foreach (expect_q[i]) begin
                if (a2b_q[i] !== expect_q[i]) begin
                    report_mismatch($sformatf("a2b_din_o %s word %0d", what, i),
                                    a2b_q[i], expect_q[i]);
                end
            end
        end
    endtask

    task automatic normal_request();
        hdr_t req;
        hdr_t rep;
        logic [KEY_LEN-1:0] par;
        int row;
        int depth;
        int fin;
        row = $urandom_range(6, 1);
        depth = $urandom_range(WORDS >> (row - 1), 1);
        req = hdr_t'($urandom);
        req.depth = 9'(depth);
        // any type with bit 2 clear is a normal request
        req.ptype = 3'($urandom_range(3, 0));
        req.row = 4'(row);
        par = parity_row(exp_key, row);
        bob_q.delete();
        expect_q.delete();
        rep = req;
        rep.msg_type = MSG_A2B_CORRECT_PARITY;
        rep.ptype = PT_NORMAL;
        expect_q.push_back(WORD_W'(rep));
        for (int k = 1; k <= depth; k++) begin
            bob_q.push_back($urandom);
            expect_q.push_back(par[KEY_LEN-1-WORD_W*(k-1) -: WORD_W] & bob_q[k-1]);
        end
        fin = finish_cnt;
        send_request(req);
        check_replies("normal");
        check_totals();
        if (finish_cnt != fin) begin
            other_errs++;
            $display("%0t: cascade_finish_o pulsed after a normal request", $time);
        end
    endtask

    task automatic top_with_errors();
        hdr_t req;
        hdr_t rep;
        logic [KEY_LEN-1:0] par;
        logic [WORD_W-1:0] pw;
        int row;
        int depth;
        int nflip;
        int pc;
        int fc;
        row = $urandom_range(6, 1);
        depth = $urandom_range(WORDS >> (row - 1), 1);
        nflip = $urandom_range(depth, 1);
        req = hdr_t'($urandom);
        req.depth = 9'(depth);
        // a first comparison with errors must not end the frame
        req.ptype = PT_FIRST_TOP_MESSAGE;
        req.row = 4'(row);
        par = parity_row(exp_key, row);
        bob_q.delete();
        expect_q.delete();
        rep = req;
        rep.msg_type = MSG_A2B_CORRECT_PARITY;
        rep.ptype = PT_TOP_COMPARE;
        rep.depth = req.depth + 9'd1;
        expect_q.push_back(WORD_W'(rep));
        // one flipped bit in each of the first nflip words
        for (int k = 1; k <= depth; k++) begin
            pw = par[KEY_LEN-1-WORD_W*(k-1) -: WORD_W];
            bob_q.push_back((k <= nflip) ? (pw ^ (32'h1 << $urandom_range(31, 0))) : pw);
            expect_q.push_back(pw);
        end
        rep = req;
        rep.msg_type = MSG_A2B_CORRECT_PARITY;
        rep.ptype = PT_TOP_MESSAGE;
        expect_q.push_back(WORD_W'(rep));
        exp_err += nflip;
        exp_leak += nflip * (row - 1);
        pc = param_cnt;
        fc = finish_cnt;
        send_request(req);
        check_replies("top with errors");
        check_totals();
        if ((param_cnt != pc) || (finish_cnt != fc)) begin
            other_errs++;
            $display("%0t: frame ended after a top-level comparison with errors", $time);
        end
    endtask

    task automatic clean_first_top();
        hdr_t req;
        hdr_t rep;
        logic [KEY_LEN-1:0] par;
        int row;
        int depth;
        int sset;
        int pc;
        int fc;
        int waited;
        row = $urandom_range(6, 4);
        depth = $urandom_range(WORDS >> (row - 1), 1);
        sset = $urandom_range(4, 1);
        req = hdr_t'($urandom);
        req.depth = 9'(depth);
        req.ptype = PT_FIRST_TOP_MESSAGE;
        req.shuffle_set = 3'(sset);
        req.row = 4'(row);
        par = parity_row(exp_key, row);
        bob_q.delete();
        expect_q.delete();
        rep = req;
        rep.msg_type = MSG_A2B_CORRECT_PARITY;
        rep.ptype = PT_TOP_COMPARE;
        rep.depth = req.depth + 9'd1;
        expect_q.push_back(WORD_W'(rep));
        for (int k = 1; k <= depth; k++) begin
            bob_q.push_back(par[KEY_LEN-1-WORD_W*(k-1) -: WORD_W]);
            expect_q.push_back(par[KEY_LEN-1-WORD_W*(k-1) -: WORD_W]);
        end
        rep = req;
        rep.msg_type = MSG_A2B_CORRECT_PARITY;
        rep.len_code = LEN_CODE_257;
        rep.depth = '0;
        rep.ptype = PT_TOP_CORRECT;
        expect_q.push_back(WORD_W'(rep));
        for (int s = 1; s <= sset; s++) begin
            exp_leak += KEY_LEN >> (row - s);
        end
        pc = param_cnt;
        fc = finish_cnt;
        send_request(req);
        check_replies("clean first top");
        waited = 0;
        while ((finish_cnt == fc) && (waited < 10)) begin
            @(negedge clk);
            waited++;
        end
        if (param_cnt != pc + 1) begin
            other_errs++;
            $display("%0t: frame_param_valid_o did not pulse once", $time);
        end else begin
            if (param_err !== ERR_CNT_W'(exp_err)) begin
                report_mismatch("frame_error_count_o at param", param_err, exp_err);
            end
            if (param_leak !== LEAK_W'(exp_leak)) begin
                report_mismatch("frame_leaked_info_o at param", param_leak, exp_leak);
            end
        end
        if (finish_cnt != fc + 1) begin
            other_errs++;
            $display("%0t: cascade_finish_o did not pulse once", $time);
        end else if (finish_cycle != param_cycle + 1) begin
            report_mismatch("cascade_finish_o cycle", finish_cycle, param_cycle + 1);
        end
        exp_err = 0;
        exp_leak = 0;
    endtask

    task automatic totals_cleared();
        check_totals();
        load_frame(1'b1, 2'd2);
    endtask

    initial begin
        void'($urandom(32'h1b686c9f));
        foreach (ram[a]) begin
            ram[a] = {$urandom, $urandom};
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();
        load_frame(1'b0, 2'd1);
        normal_request();
        top_with_errors();
        clean_first_top();
        totals_cleared();
        normal_request();
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        if ((val_errs + other_errs) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: vlog.f
cascade_pkg.sv
key_if.sv
sifted_key_loader.sv
key_parity_store.sv
parity_responder.sv
cascade_sequencer.sv
alice_cascade_top.sv
tb_alice_cascade.sv
